//--- hdl/coreSettings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

//////////////////////////////
// core dimensions
//////////////////////////////

// data and address width
`define XLEN 32

// architectural registers including x0
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- hdl/corePkg.sv
package corePkg;

  //////////////////////////////
  // instruction encodings
  //////////////////////////////

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    opImm    = 7'b0010011,
    opReg    = 7'b0110011,
    opLui    = 7'b0110111,
    opBranch = 7'b1100011,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111
  } opcodeE;

  //////////////////////////////
  // control selections
  //////////////////////////////

  typedef enum logic [2:0] {
    aluAdd   = 3'd0,
    aluSub   = 3'd1,
    aluAnd   = 3'd2,
    aluOr    = 3'd3,
    aluXor   = 3'd4,
    aluSlt   = 3'd5,
    aluPassB = 3'd6
  } aluOpE;

  typedef enum logic [1:0] {
    immI = 2'd0,
    immB = 2'd1,
    immJ = 2'd2,
    immU = 2'd3
  } immKindE;

  // next pc is pc + 4, pc + imm or rs1 + imm
  typedef enum logic [1:0] {
    pcSeq = 2'd0,
    pcRel = 2'd1,
    pcReg = 2'd2
  } pcSrcE;

endpackage

//--- hdl/idExIf.sv
`include "coreSettings.svh"

interface idExIf import corePkg::*; ();

  logic             valid;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] opA;
  // already muxed between rs2 and immediate
  logic [`XLEN-1:0] opB;
  logic [4:0]       rd;
  logic             regWrite;
  aluOpE            aluOp;
  // write pc + 4 instead of the alu result
  logic             link;

  modport source (
    output valid, pc, opA, opB, rd, regWrite, aluOp, link
  );

  modport sink (
    input valid, pc, opA, opB, rd, regWrite, aluOp, link
  );

endinterface

//--- hdl/fetchStage.sv
`include "coreSettings.svh"

module fetchStage import corePkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             stall_i,
  input  pcSrcE            pcSrc_i,
  input  logic [`XLEN-1:0] pcTarget_i,
  input  logic [`XLEN-1:0] regTarget_i,
  input  logic [31:0]      imemData_i,
  output logic [`XLEN-1:0] imemAddr_o,
  output logic [31:0]      instr_o,
  output logic [`XLEN-1:0] pc_o,
  output logic             valid_o
);

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] pcNext;

  always_comb begin
    case (pcSrc_i)
      pcRel:   pcNext = pcTarget_i;
      pcReg:   pcNext = regTarget_i;
      default: pcNext = pc + 4;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc <= `RESET_PC;
    end else if (!stall_i) begin
      pc <= pcNext;
    end
  end

  assign imemAddr_o = pc;

  //////////////////////////////
  // IF/ID register
  //////////////////////////////

  // a redirect squashes the word fetched this cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= (pcSrc_i == pcSeq);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      instr_o <= imemData_i;
      pc_o    <= pc;
    end
  end

endmodule

//--- hdl/decodeCtrl.sv
module decodeCtrl import corePkg::*; (
  input  logic [31:0] instr_i,
  output aluOpE       aluOp_o,
  output immKindE     immKind_o,
  output logic        useImm_o,
  output logic        regWrite_o,
  output logic        branch_o,
  output logic        jump_o,
  output logic        jumpReg_o,
  output logic        link_o
);

  opcodeE     opcode;
  logic [2:0] funct3;
  logic       funct7b5;

  assign opcode   = opcodeE'(instr_i[6:0]);
  assign funct3   = instr_i[14:12];
  assign funct7b5 = instr_i[30];

  always_comb begin
    // no-op unless something below claims the opcode
    aluOp_o    = aluAdd;
    immKind_o  = immI;
    useImm_o   = 1'b0;
    regWrite_o = 1'b0;
    branch_o   = 1'b0;
    jump_o     = 1'b0;
    jumpReg_o  = 1'b0;
    link_o     = 1'b0;

    case (opcode)
      opReg, opImm: begin
        useImm_o   = (opcode == opImm);
        regWrite_o = 1'b1;
        case (funct3)
          3'b000:  aluOp_o = (opcode == opReg && funct7b5) ? aluSub : aluAdd;
          3'b010:  aluOp_o = aluSlt;
          3'b100:  aluOp_o = aluXor;
          3'b110:  aluOp_o = aluOr;
          3'b111:  aluOp_o = aluAnd;
          // shifts and unsigned compares are not supported
          default: regWrite_o = 1'b0;
        endcase
      end
      opLui: begin
        immKind_o  = immU;
        useImm_o   = 1'b1;
        regWrite_o = 1'b1;
        aluOp_o    = aluPassB;
      end
      opBranch: begin
        immKind_o = immB;
        branch_o  = 1'b1;
      end
      opJal: begin
        immKind_o  = immJ;
        jump_o     = 1'b1;
        link_o     = 1'b1;
        regWrite_o = 1'b1;
      end
      opJalr: begin
        jumpReg_o  = 1'b1;
        link_o     = 1'b1;
        regWrite_o = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- hdl/regFile.sv
`include "coreSettings.svh"

module regFile (
  input  logic             clk_i,
  input  logic [4:0]       rs1_i,
  input  logic [4:0]       rs2_i,
  input  logic [4:0]       writeAddr_i,
  input  logic             writeEnable_i,
  input  logic [`XLEN-1:0] writeData_i,
  output logic [`XLEN-1:0] rd1_o,
  output logic [`XLEN-1:0] rd2_o,
  output logic [`XLEN-1:0] a0_o
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // x0 is never written
  always_ff @(posedge clk_i) begin
    if (writeEnable_i && writeAddr_i != 5'd0) begin
      regs[writeAddr_i] <= writeData_i;
    end
  end

  // decode forwards the same-cycle write
  assign rd1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
  assign rd2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

  // x10 tap for observing results from outside
  assign a0_o = regs[10];

endmodule

//--- hdl/immExtend.sv
`include "coreSettings.svh"

module immExtend import corePkg::*; (
  input  logic [31:7]      instr_i,
  input  immKindE          immKind_i,
  output logic [`XLEN-1:0] imm_o
);

  logic sign;

  assign sign = instr_i[31];

  always_comb begin
    case (immKind_i)
      immB: begin
        imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
      end
      immJ: begin
        imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
      end
      // upper 20 bits over zeroed low bits
      immU: begin
        imm_o = {instr_i[31:12], 12'b0};
      end
      default: begin
        imm_o = {{20{sign}}, instr_i[31:20]};
      end
    endcase
  end

endmodule

//--- hdl/branchUnit.sv
`include "coreSettings.svh"

module branchUnit import corePkg::*; (
  input  logic [`XLEN-1:0] opA_i,
  input  logic [`XLEN-1:0] opB_i,
  input  logic [2:0]       funct3_i,
  input  logic             branch_i,
  input  logic             jump_i,
  input  logic             jumpReg_i,
  input  logic             valid_i,
  output pcSrcE            pcSrc_o
);

  logic taken;

  // beq, bne, blt, bge
  always_comb begin
    case (funct3_i)
      3'b000:  taken = (opA_i == opB_i);
      3'b001:  taken = (opA_i != opB_i);
      3'b100:  taken = ($signed(opA_i) < $signed(opB_i));
      3'b101:  taken = ($signed(opA_i) >= $signed(opB_i));
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (!valid_i) begin
      pcSrc_o = pcSeq;
    end else if (jumpReg_i) begin
      pcSrc_o = pcReg;
    end else if (jump_i || (branch_i && taken)) begin
      pcSrc_o = pcRel;
    end else begin
      pcSrc_o = pcSeq;
    end
  end

endmodule

//--- hdl/idStage.sv
`include "coreSettings.svh"

module idStage import corePkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             stall_i,
  input  logic [31:0]      instr_i,
  input  logic [`XLEN-1:0] pc_i,
  input  logic             valid_i,
  input  logic             writeEnable_i,
  input  logic [4:0]       writeAddr_i,
  input  logic [`XLEN-1:0] writeData_i,
  output pcSrcE            pcSrc_o,
  output logic [`XLEN-1:0] pcTarget_o,
  output logic [`XLEN-1:0] regTarget_o,
  output logic [`XLEN-1:0] a0_o,
  idExIf.source            exBus
);

  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [4:0]       rd;
  aluOpE            aluOp;
  immKindE          immKind;
  logic             useImm;
  logic             regWrite;
  logic             branch;
  logic             jump;
  logic             jumpReg;
  logic             link;
  logic [`XLEN-1:0] rd1;
  logic [`XLEN-1:0] rd2;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] fwdA;
  logic [`XLEN-1:0] fwdB;
  logic [`XLEN-1:0] regSum;

  assign rs1 = instr_i[19:15];
  assign rs2 = instr_i[24:20];
  assign rd  = instr_i[11:7];

  decodeCtrl i_decodeCtrl (
    .instr_i    (instr_i),
    .aluOp_o    (aluOp),
    .immKind_o  (immKind),
    .useImm_o   (useImm),
    .regWrite_o (regWrite),
    .branch_o   (branch),
    .jump_o     (jump),
    .jumpReg_o  (jumpReg),
    .link_o     (link)
  );

  regFile i_regFile (
    .clk_i         (clk_i),
    .rs1_i         (rs1),
    .rs2_i         (rs2),
    .writeAddr_i   (writeAddr_i),
    .writeEnable_i (writeEnable_i),
    .writeData_i   (writeData_i),
    .rd1_o         (rd1),
    .rd2_o         (rd2),
    .a0_o          (a0_o)
  );

  immExtend i_immExtend (
    .instr_i   (instr_i[31:7]),
    .immKind_i (immKind),
    .imm_o     (imm)
  );

  //////////////////////////////
  // forwarding from execute
  //////////////////////////////

  assign fwdA = (writeEnable_i && writeAddr_i == rs1 && rs1 != 5'd0) ? writeData_i : rd1;
  assign fwdB = (writeEnable_i && writeAddr_i == rs2 && rs2 != 5'd0) ? writeData_i : rd2;

  // jump and branch targets
  assign pcTarget_o  = pc_i + imm;
  assign regSum      = fwdA + imm;
  assign regTarget_o = {regSum[`XLEN-1:1], 1'b0};

  branchUnit i_branchUnit (
    .opA_i     (fwdA),
    .opB_i     (fwdB),
    .funct3_i  (instr_i[14:12]),
    .branch_i  (branch),
    .jump_i    (jump),
    .jumpReg_i (jumpReg),
    .valid_i   (valid_i),
    .pcSrc_o   (pcSrc_o)
  );

  //////////////////////////////
  // ID/EX register
  //////////////////////////////

  // squashed slots enter execute with controls zeroed
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exBus.valid    <= 1'b0;
      exBus.regWrite <= 1'b0;
      exBus.link     <= 1'b0;
    end else if (!stall_i) begin
      exBus.valid    <= valid_i;
      exBus.regWrite <= regWrite & valid_i;
      exBus.link     <= link & valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      exBus.pc    <= pc_i;
      exBus.opA   <= fwdA;
      exBus.opB   <= useImm ? imm : fwdB;
      exBus.rd    <= rd;
      exBus.aluOp <= aluOp;
    end
  end

endmodule

//--- hdl/executeStage.sv
`include "coreSettings.svh"

module executeStage import corePkg::*; (
  idExIf.sink              exBus,
  input  logic             stall_i,
  output logic             writeEnable_o,
  output logic [4:0]       writeAddr_o,
  output logic [`XLEN-1:0] writeData_o,
  output logic             retireValid_o,
  output logic [`XLEN-1:0] retirePc_o,
  output logic [4:0]       retireRd_o
);

  logic [`XLEN-1:0] aluOut;
  logic [`XLEN-1:0] result;
  logic             writesReg;

  always_comb begin
    case (exBus.aluOp)
      aluSub:   aluOut = exBus.opA - exBus.opB;
      aluAnd:   aluOut = exBus.opA & exBus.opB;
      aluOr:    aluOut = exBus.opA | exBus.opB;
      aluXor:   aluOut = exBus.opA ^ exBus.opB;
      aluSlt:   aluOut = {{(`XLEN-1){1'b0}}, $signed(exBus.opA) < $signed(exBus.opB)};
      aluPassB: aluOut = exBus.opB;
      default:  aluOut = exBus.opA + exBus.opB;
    endcase
  end

  // return address for jal and jalr
  assign result = exBus.link ? exBus.pc + 4 : aluOut;

  // x0 targets count as no write
  assign writesReg = exBus.valid && exBus.regWrite && exBus.rd != 5'd0;

  //////////////////////////////
  // writeback
  //////////////////////////////

  assign writeEnable_o = writesReg && !stall_i;
  assign writeAddr_o   = exBus.rd;
  assign writeData_o   = writesReg ? result : '0;

  // one report per instruction leaving the pipe
  assign retireValid_o = exBus.valid && !stall_i;
  assign retirePc_o    = exBus.pc;
  assign retireRd_o    = writesReg ? exBus.rd : 5'd0;

endmodule

//--- hdl/riscvCore.sv
`include "coreSettings.svh"

module riscvCore import corePkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             stall_i,
  input  logic [31:0]      imemData_i,
  output logic [`XLEN-1:0] imemAddr_o,
  output logic             retireValid_o,
  output logic [`XLEN-1:0] retirePc_o,
  output logic [4:0]       retireRd_o,
  output logic [`XLEN-1:0] retireData_o,
  output logic [`XLEN-1:0] a0_o
);

  pcSrcE            pcSrc;
  logic [`XLEN-1:0] pcTarget;
  logic [`XLEN-1:0] regTarget;
  logic [31:0]      instr;
  logic [`XLEN-1:0] pc;
  logic             valid;
  logic             writeEnable;
  logic [4:0]       writeAddr;
  logic [`XLEN-1:0] writeData;

  idExIf exBus ();

  fetchStage i_fetchStage (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .stall_i     (stall_i),
    .pcSrc_i     (pcSrc),
    .pcTarget_i  (pcTarget),
    .regTarget_i (regTarget),
    .imemData_i  (imemData_i),
    .imemAddr_o  (imemAddr_o),
    .instr_o     (instr),
    .pc_o        (pc),
    .valid_o     (valid)
  );

  idStage i_idStage (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .stall_i       (stall_i),
    .instr_i       (instr),
    .pc_i          (pc),
    .valid_i       (valid),
    .writeEnable_i (writeEnable),
    .writeAddr_i   (writeAddr),
    .writeData_i   (writeData),
    .pcSrc_o       (pcSrc),
    .pcTarget_o    (pcTarget),
    .regTarget_o   (regTarget),
    .a0_o          (a0_o),
    .exBus         (exBus.source)
  );

  executeStage i_executeStage (
    .exBus         (exBus.sink),
    .stall_i       (stall_i),
    .writeEnable_o (writeEnable),
    .writeAddr_o   (writeAddr),
    .writeData_o   (writeData),
    .retireValid_o (retireValid_o),
    .retirePc_o    (retirePc_o),
    .retireRd_o    (retireRd_o)
  );

  assign retireData_o = writeData;

endmodule

//--- dv/coreProgram.svh
`ifndef CORE_PROGRAM_SVH
`define CORE_PROGRAM_SVH

//////////////////////////////
// program image
//////////////////////////////

localparam int          progMax   = 64;
localparam logic [6:0]  opcImm    = 7'b0010011;
localparam logic [6:0]  opcReg    = 7'b0110011;
localparam logic [6:0]  opcLui    = 7'b0110111;
localparam logic [6:0]  opcBranch = 7'b1100011;
localparam logic [6:0]  opcJal    = 7'b1101111;
localparam logic [6:0]  opcJalr   = 7'b1100111;
// jal x0 with offset 0 spins in place
localparam logic [31:0] loopWord  = {25'd0, opcJal};

logic [31:0] progMem [progMax];
int          progLen = 0;

// expected retirements with the oldest first
logic [31:0] expPcQ [$];
logic [4:0]  expRdQ [$];
logic [31:0] expDataQ [$];
logic [31:0] modelA0;
logic [31:0] endPc;

function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, opcReg};
endfunction

function automatic logic [31:0] encI(input logic [31:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
  return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] encB(input logic [31:0] off, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opcBranch};
endfunction

function automatic logic [31:0] encJ(input logic [31:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, opcJal};
endfunction

task automatic emit(input logic [31:0] word);
  progMem[progLen] = word;
  progLen++;
endtask

task automatic buildProgram();
  // alu ops forming mostly a dependent chain
  emit(encI(5, 5'd0, 3'b000, 5'd1, opcImm));
  emit(encI(-3, 5'd0, 3'b000, 5'd2, opcImm));
  emit(encR(7'd0, 5'd2, 5'd1, 3'b000, 5'd3));
  emit(encR(7'b0100000, 5'd1, 5'd3, 3'b000, 5'd4));
  emit(encR(7'd0, 5'd3, 5'd4, 3'b100, 5'd5));
  emit(encR(7'd0, 5'd1, 5'd5, 3'b110, 5'd6));
  emit(encR(7'd0, 5'd4, 5'd6, 3'b111, 5'd7));
  emit(encR(7'd0, 5'd1, 5'd2, 3'b010, 5'd8));
  emit(encI(4, 5'd1, 3'b010, 5'd9, opcImm));
  emit(encI(15, 5'd1, 3'b100, 5'd10, opcImm));
  emit(encI(32'h100, 5'd2, 3'b110, 5'd11, opcImm));
  emit(encI(32'h7f, 5'd2, 3'b111, 5'd12, opcImm));
  emit({20'h12345, 5'd13, opcLui});
  emit(encI(32'h678, 5'd13, 3'b000, 5'd13, opcImm));
  // unsupported fence retires as a no-op
  emit(32'h0000_000f);
  // taken branches skip a poison addi to a0
  emit(encB(8, 5'd1, 5'd1, 3'b000));
  emit(encI(99, 5'd0, 3'b000, 5'd10, opcImm));
  emit(encB(8, 5'd1, 5'd1, 3'b001));
  emit(encB(8, 5'd1, 5'd2, 3'b100));
  emit(encI(98, 5'd0, 3'b000, 5'd10, opcImm));
  emit(encB(8, 5'd1, 5'd2, 3'b101));
  emit(encB(8, 5'd2, 5'd1, 3'b101));
  emit(encI(97, 5'd0, 3'b000, 5'd10, opcImm));
  emit(encB(8, 5'd2, 5'd1, 3'b100));
  emit(encB(8, 5'd2, 5'd1, 3'b000));
  emit(encB(8, 5'd2, 5'd1, 3'b001));
  emit(encI(96, 5'd0, 3'b000, 5'd10, opcImm));
  // jal over two words and then jalr to an odd sum
  emit(encJ(12, 5'd14));
  emit(encI(95, 5'd0, 3'b000, 5'd10, opcImm));
  emit(encI(94, 5'd0, 3'b000, 5'd10, opcImm));
  emit(encI(141, 5'd0, 3'b000, 5'd15, opcImm));
  emit(encI(0, 5'd15, 3'b000, 5'd16, opcJalr));
  emit(encI(93, 5'd0, 3'b000, 5'd10, opcImm));
  emit(encI(92, 5'd0, 3'b000, 5'd10, opcImm));
  emit(encI(91, 5'd0, 3'b000, 5'd10, opcImm));
  // countdown loop adding 3, 2 and 1 to a0
  emit(encI(3, 5'd0, 3'b000, 5'd17, opcImm));
  emit(encR(7'd0, 5'd17, 5'd10, 3'b000, 5'd10));
  emit(encI(-1, 5'd17, 3'b000, 5'd17, opcImm));
  emit(encB(-8, 5'd0, 5'd17, 3'b001));
  // x0 as a destination
  emit(encJ(8, 5'd0));
  emit(encI(90, 5'd0, 3'b000, 5'd10, opcImm));
  emit(encI(55, 5'd1, 3'b000, 5'd0, opcImm));
  emit(encR(7'd0, 5'd1, 5'd0, 3'b000, 5'd18));
endtask

//////////////////////////////
// reference model
//////////////////////////////

task automatic runModel();
  logic [31:0] regs [32];
  logic [31:0] pc;
  logic [31:0] nextPc;
  logic [31:0] instr;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] immI;
  logic [31:0] value;
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic        writes;
  logic        taken;
  logic        done;
  int          steps;
  int          i;
  for (i = 0; i < 32; i++) begin
    regs[i] = '0;
  end
  pc = `RESET_PC;
  done = 1'b0;
  steps = 0;
  while (!done && steps < 1000) begin
    if (pc < progLen * 4) begin
      instr = progMem[pc >> 2];
    end else begin
      instr = loopWord;
    end
    rd = instr[11:7];
    f3 = instr[14:12];
    a = regs[instr[19:15]];
    b = regs[instr[24:20]];
    immI = {{20{instr[31]}}, instr[31:20]};
    nextPc = pc + 4;
    writes = 1'b0;
    value = '0;
    taken = 1'b0;
    case (instr[6:0])
      opcImm, opcReg: begin
        if (instr[6:0] == opcImm) begin
          b = immI;
        end
        writes = 1'b1;
        case (f3)
          3'b000:  value = (instr[6:0] == opcReg && instr[30]) ? a - b : a + b;
          3'b010:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b100:  value = a ^ b;
          3'b110:  value = a | b;
          3'b111:  value = a & b;
          default: writes = 1'b0;
        endcase
      end
      opcLui: begin
        writes = 1'b1;
        value = {instr[31:12], 12'd0};
      end
      opcBranch: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = $signed(a) < $signed(b);
          3'b101:  taken = $signed(a) >= $signed(b);
          default: taken = 1'b0;
        endcase
        if (taken) begin
          nextPc = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0};
        end
      end
      opcJal: begin
        writes = 1'b1;
        value = pc + 4;
        nextPc = pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
      end
      opcJalr: begin
        writes = 1'b1;
        value = pc + 4;
        nextPc = (a + immI) & ~32'd1;
      end
      default: ;
    endcase
    // rd zero and non-writing ops report x0 and a zero value
    if (writes && rd != 5'd0) begin
      regs[rd] = value;
      expRdQ.push_back(rd);
      expDataQ.push_back(value);
    end else begin
      expRdQ.push_back(5'd0);
      expDataQ.push_back(32'd0);
    end
    expPcQ.push_back(pc);
    done = (nextPc == pc);
    pc = nextPc;
    steps++;
  end
  endPc = pc;
  modelA0 = regs[10];
endtask

`endif

//--- dv/coreTb.sv
`include "coreSettings.svh"

module coreTb;

  localparam int          clkPeriod   = 20;
  localparam int          resetCycles = 16;
  localparam logic [31:0] lfsrSeed    = 32'h677050f4;

  logic             clk_i = 1'b0;
  logic             reset_i;
  logic             stall_i;
  logic [31:0]      imemData_i;
  logic [`XLEN-1:0] imemAddr_o;
  logic             retireValid_o;
  logic [`XLEN-1:0] retirePc_o;
  logic [4:0]       retireRd_o;
  logic [`XLEN-1:0] retireData_o;
  logic [`XLEN-1:0] a0_o;

  `include "coreProgram.svh"

  logic [31:0] lfsr;
  logic [31:0] expPc;
  logic [4:0]  expRd;
  logic [31:0] expData;
  logic [31:0] lastAddr;
  int          expCount = 0;
  int          retired = 0;
  int          errors = 0;

  riscvCore i_riscvCore (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .stall_i       (stall_i),
    .imemData_i    (imemData_i),
    .imemAddr_o    (imemAddr_o),
    .retireValid_o (retireValid_o),
    .retirePc_o    (retirePc_o),
    .retireRd_o    (retireRd_o),
    .retireData_o  (retireData_o),
    .a0_o          (a0_o)
  );

  always #(clkPeriod / 2) clk_i = ~clk_i;

  // instruction memory answers in the same cycle
  always_comb begin
    if (imemAddr_o < progLen * 4) begin
      imemData_i = progMem[imemAddr_o >> 2];
    end else begin
      imemData_i = loopWord;
    end
  end

  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // advance to the next expected entry on every retirement
  always @(posedge clk_i) begin
    lastAddr <= imemAddr_o;
    if (!reset_i && retireValid_o) begin
      retired <= retired + 1;
      if (expPcQ.size() != 0) begin
        expPc   <= expPcQ.pop_front();
        expRd   <= expRdQ.pop_front();
        expData <= expDataQ.pop_front();
      end else begin
        expPc   <= endPc;
        expRd   <= 5'd0;
        expData <= 32'd0;
      end
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  retirePcCheck: assert property (@(posedge clk_i) disable iff (reset_i)
    retireValid_o |-> retirePc_o == expPc)
    else begin
      errors = errors + 1;
      $display("[FAIL] %0t retirePc_o expected %h actual %h",
               $time, $sampled(expPc), $sampled(retirePc_o));
    end

  retireRdCheck: assert property (@(posedge clk_i) disable iff (reset_i)
    retireValid_o |-> retireRd_o == expRd)
    else begin
      errors = errors + 1;
      $display("[FAIL] %0t retireRd_o expected %0d actual %0d",
               $time, $sampled(expRd), $sampled(retireRd_o));
    end

  retireDataCheck: assert property (@(posedge clk_i) disable iff (reset_i)
    retireValid_o |-> retireData_o == expData)
    else begin
      errors = errors + 1;
      $display("[FAIL] %0t retireData_o expected %h actual %h",
               $time, $sampled(expData), $sampled(retireData_o));
    end

  stallRetireCheck: assert property (@(posedge clk_i) disable iff (reset_i)
    stall_i |-> !retireValid_o)
    else begin
      errors = errors + 1;
      $display("[FAIL] %0t retireValid_o expected 0 actual %b",
               $time, $sampled(retireValid_o));
    end

  // pc frozen across a stalled cycle
  stallAddrCheck: assert property (@(posedge clk_i) disable iff (reset_i)
    stall_i |=> imemAddr_o == lastAddr)
    else begin
      errors = errors + 1;
      $display("[FAIL] %0t imemAddr_o expected %h actual %h",
               $time, $sampled(lastAddr), $sampled(imemAddr_o));
    end

  resetStateCheck: assert property (@(posedge clk_i)
    $fell(reset_i) |-> imemAddr_o == `RESET_PC && !retireValid_o)
    else begin
      errors = errors + 1;
      $display("[FAIL] %0t imemAddr_o expected %h actual %h, retireValid_o %b",
               $time, `RESET_PC, $sampled(imemAddr_o), $sampled(retireValid_o));
    end

  task automatic reportAndFinish(input bit timedOut);
    $display("retired %0d of %0d expected, %0d errors", retired, expCount, errors);
    if (errors == 0 && !timedOut) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    logic bitA;
    logic bitB;
    reset_i = 1'b1;
    stall_i = 1'b0;
    lfsr = lfsrSeed;
    buildProgram();
    runModel();
    expCount = expPcQ.size();
    expPc = expPcQ.pop_front();
    expRd = expRdQ.pop_front();
    expData = expDataQ.pop_front();
    repeat (resetCycles) @(posedge clk_i);
    reset_i <= 1'b0;
    // stall on about one cycle in four
    while (retired < expCount) begin
      @(posedge clk_i);
      lfsr = lfsrNext(lfsr);
      bitA = lfsr[0];
      lfsr = lfsrNext(lfsr);
      bitB = lfsr[0];
      stall_i <= bitA & bitB;
    end
    stall_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    a0Check: assert (a0_o == modelA0)
      else begin
        errors = errors + 1;
        $display("[FAIL] %0t a0_o expected %h actual %h", $time, modelA0, a0_o);
      end
    reportAndFinish(1'b0);
  end

  // eight cycles per program word is far beyond the worst case
  initial begin
    @(negedge reset_i);
    #(progLen * 8 * clkPeriod);
    $display("timeout: the core did not retire the whole program in time");
    reportAndFinish(1'b1);
  end

endmodule

//--- filelist.f
+incdir+hdl
+incdir+dv
hdl/corePkg.sv
hdl/idExIf.sv
hdl/fetchStage.sv
hdl/decodeCtrl.sv
hdl/regFile.sv
hdl/immExtend.sv
hdl/branchUnit.sv
hdl/idStage.sv
hdl/executeStage.sv
hdl/riscvCore.sv
dv/coreTb.sv
